// ==== bench/conv_props.sv ====
// watches the output handshake and the window stall; attached to every conv_top by bind
`timescale 1ns/1ps

module conv_props import conv_pkg::*; (
    input logic      clk,
    input logic      reset,
    input out_vec_t  i_out_result,
    input logic      i_out_valid,
    input logic      i_out_last,
    input logic      i_out_ready,
    input logic      i_in_ready,
    input win_beat_t i_win,
    input logic      i_win_valid,
    input logic      i_win_ready
);

    // result and last hold while the consumer stalls
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (i_out_valid && !i_out_ready) |=> ($stable(i_out_result) && $stable(i_out_last)))
        else $error("result or last changed under back-pressure");

    // no result offered right after reset
    a_reset: assert property (@(posedge clk) reset |=> !i_out_valid)
        else $error("o_valid high after reset");

    // window blocked by the MAC stays offered and unchanged
    a_stall: assert property (@(posedge clk) disable iff (reset)
        (i_win_valid && !i_win_ready) |=> (i_win_valid && $stable(i_win)))
        else $error("window dropped or changed while the MAC was busy");

endmodule

bind conv_top conv_props props_i (
    .clk          (clk),
    .reset        (reset),
    .i_out_result (o_result),
    .i_out_valid  (o_valid),
    .i_out_last   (o_last),
    .i_out_ready  (i_ready),
    .i_in_ready   (o_ready_in),
    .i_win        (win),
    .i_win_valid  (win_valid),
    .i_win_ready  (win_ready)
);

// ==== bench/conv_tb.sv ====
// images are fixed at 6 rows; coefficients are rewritten only once every result of an image has left
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_tb import conv_pkg::*; ();

    localparam int W       = `CONV_IMG_WIDTH;
    localparam int ROWS    = 6;
    localparam int K       = `CONV_K;
    localparam int K2      = K * K;
    localparam int NCH     = `CONV_OUT_CH;
    localparam int NUM_IMG = 3;
    // every pixel may cost a full MAC pass plus handshake slack
    localparam int TIMEOUT = NUM_IMG * ROWS * W * (3 * NCH + 4) * 4;

    logic      clk = 1'b0;
    logic      reset;
    pixel_t    i_pixel;
    logic      i_valid;
    logic      i_last;
    logic      o_ready_in;
    coef_wr_t  i_coef_wr;
    out_vec_t  o_result;
    logic      o_valid;
    logic      o_last;
    logic      i_ready;

    // model state
    pixel_t    img [ROWS][W];
    pixel_t    wgt [NCH][K2];
    pixel_t    bias [NCH];
    out_vec_t  exp_res_q [$];
    logic      exp_last_q [$];
    out_vec_t  exp_res;
    logic      exp_last;
    int        exp_cnt = 0;
    int        got_cnt = 0;
    int        clamp_cnt = 0;
    int        cycles = 0;
    // pixel stream and ready pattern draw from separate states
    logic [31:0] stim_st = 32'd66;
    logic [31:0] ready_st = ~32'd66;

    always #20 clk = ~clk;

    conv_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .i_pixel    (i_pixel),
        .i_valid    (i_valid),
        .i_last     (i_last),
        .o_ready_in (o_ready_in),
        .i_coef_wr  (i_coef_wr),
        .o_result   (o_result),
        .o_valid    (o_valid),
        .o_last     (o_last),
        .i_ready    (i_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // uniform draw in lo..hi from the stimulus stream
    function automatic int pick(input int lo, input int hi);
        stim_st = xorshift(stim_st);
        return lo + int'(stim_st % (hi - lo + 1));
    endfunction

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // one register write per cycle, bias sits at tap K*K
    task automatic load_coefs();
        coef_wr_t w;
        pixel_t   v;
        for (int ch = 0; ch < NCH; ch++) begin
            for (int tap = 0; tap <= K2; tap++) begin
                // +-1.0 in the 8 fraction bit format
                v = pixel_t'(pick(-256, 256));
                if (tap == K2) begin
                    bias[ch] = v;
                end else begin
                    wgt[ch][tap] = v;
                end
                w.en    = 1'b1;
                w.ch    = ch_idx_t'(ch);
                w.tap   = tap[TAP_BITS-1:0];
                w.value = v;
                i_coef_wr <= w;
                @(posedge clk);
            end
        end
        i_coef_wr <= '0;
        @(posedge clk);
    endtask

    // unpadded windows in row-major order, row 0 of a window is the oldest
    task automatic predict_image();
        longint   acc;
        longint   sh;
        pixel_t   v;
        out_vec_t res;
        for (int y = 0; y + K <= ROWS; y++) begin
            for (int x = 0; x + K <= W; x++) begin
                for (int ch = 0; ch < NCH; ch++) begin
                    acc = 0;
                    for (int r = 0; r < K; r++) begin
                        for (int c = 0; c < K; c++) begin
                            acc += longint'(wgt[ch][r*K + c]) * longint'(img[y+r][x+c]);
                        end
                    end
                    sh = acc >>> `CONV_FRAC_BITS;
                    v  = sh[`CONV_VALUE_BITS-1:0];
                    v  = v + bias[ch];
                    if (`CONV_RELU != 0 && v < 0) begin
                        v = '0;
                        clamp_cnt++;
                    end
                    res[ch] = v;
                end
                exp_res_q.push_back(res);
                exp_last_q.push_back((y == ROWS - K) && (x == W - K));
                exp_cnt++;
            end
        end
    endtask

    task automatic send_image();
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < W; x++) begin
                // occasional idle gap before a pixel
                if (pick(0, 3) == 0) begin
                    i_valid <= 1'b0;
                    repeat (pick(1, 3)) @(posedge clk);
                end
                i_pixel <= img[y][x];
                i_last  <= (y == ROWS - 1) && (x == W - 1);
                i_valid <= 1'b1;
                @(posedge clk);
                while (!o_ready_in) @(posedge clk);
            end
        end
        i_valid <= 1'b0;
        i_last  <= 1'b0;
    endtask

    initial begin
        i_pixel   = '0;
        i_valid   = 1'b0;
        i_last    = 1'b0;
        i_coef_wr = '0;
        i_ready   = 1'b0;
        reset     = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < NUM_IMG; n++) begin
            // engine must be idle before the coefficients change
            while (got_cnt != exp_cnt) @(posedge clk);
            load_coefs();
            for (int y = 0; y < ROWS; y++) begin
                for (int x = 0; x < W; x++) begin
                    // +-4.0 pixels
                    img[y][x] = pixel_t'(pick(-1024, 1024));
                end
            end
            predict_image();
            send_image();
        end
        while (got_cnt != exp_cnt) @(posedge clk);
        // quiet tail so a duplicate result would still be caught
        repeat (20) @(posedge clk);
        assert (`CONV_RELU == 0 || clamp_cnt > 0) else begin
            $display("no window produced a negative result, ReLU was never exercised");
            stop_on_error();
        end
        $display("Test OK");
        $finish;
    end

    // output check and random back-pressure, sampled at the edge where the transfer happens
    always @(posedge clk) begin
        if (!reset && o_valid && i_ready) begin
            assert (exp_res_q.size() != 0) else begin
                $display("a result arrived at %0t with none expected", $time);
                stop_on_error();
            end
            exp_res  = exp_res_q.pop_front();
            exp_last = exp_last_q.pop_front();
            assert (o_result == exp_res) else begin
                $display("FAILED at %0t: result %h, expected %h", $time, o_result, exp_res);
                stop_on_error();
            end
            assert (o_last == exp_last) else begin
                $display("FAILED at %0t: last %b, expected %b", $time, o_last, exp_last);
                stop_on_error();
            end
            got_cnt <= got_cnt + 1;
        end
        ready_st = xorshift(ready_st);
        // ready about three quarters of the time
        i_ready <= (ready_st[1:0] != 2'd0);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < TIMEOUT) else begin
            $display("the run hung, results still missing after %0d cycles", TIMEOUT);
            stop_on_error();
        end
    end

endmodule

// ==== conv.f ====
+incdir+hw
hw/conv_pkg.sv
hw/row_ram.sv
hw/window_buffer.sv
hw/coef_regs.sv
hw/channel_mac.sv
hw/conv_top.sv
bench/conv_props.sv
bench/conv_tb.sv

// ==== hw/channel_mac.sv ====
// one window at a time, 3 cycles per channel plus one; results wrap at 16 bits without saturation
`timescale 1ns/1ps
`include "conv_defs.svh"

module channel_mac import conv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  win_beat_t i_win,
    input  logic      i_win_valid,
    output logic      o_win_ready,
    output ch_idx_t   o_ch,
    input  window_t   i_weights,
    input  pixel_t    i_bias,
    output out_vec_t  o_result,
    output logic      o_valid,
    output logic      o_last,
    input  logic      i_ready
);

    localparam int  K2      = `CONV_K * `CONV_K;
    localparam int  VB      = `CONV_VALUE_BITS;
    localparam int  NCH     = `CONV_OUT_CH;
    localparam bit  RELU_ON = (`CONV_RELU != 0);

    // held window and schedule state
    window_t              win_q;
    logic                 last_q;
    logic                 busy_q;
    ch_idx_t              ch_q;
    logic [1:0]           ph_q;
    logic                 fin_q;
    logic                 valid_q;
    logic                 take;
    logic                 running;
    // datapath registers
    window_t              wgt_q;
    logic signed [2*VB-1:0] sum_q;
    logic signed [2*VB-1:0] sum_d;
    logic signed [2*VB-1:0] shifted;
    pixel_t               scaled;
    pixel_t               biased;
    pixel_t               res_val;
    out_vec_t             res_q;

    // slot is free only once the previous result has left
    assign o_win_ready = !busy_q;
    assign take        = i_win_valid && !busy_q;
    assign running     = busy_q && !fin_q && !valid_q;
    assign o_ch        = ch_q;

    // sum of products at full width
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < K2; i++) begin
            sum_d = sum_d + $signed(wgt_q[i]) * $signed(win_q[i]);
        end
    end

    // drop the extra fraction bits, keep the low word
    assign shifted = sum_q >>> `CONV_FRAC_BITS;
    assign scaled  = shifted[VB-1:0];
    assign biased  = scaled + i_bias;
    assign res_val = (RELU_ON && biased[VB-1]) ? '0 : biased;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q  <= 1'b0;
            last_q  <= 1'b0;
            ch_q    <= '0;
            ph_q    <= '0;
            fin_q   <= 1'b0;
            valid_q <= 1'b0;
        end else if (take) begin
            busy_q <= 1'b1;
            last_q <= i_win.last;
            ch_q   <= '0;
            ph_q   <= '0;
        end else if (running) begin
            // phase 0 weights, 1 sum, 2 store, then next channel
            if (ph_q == 2'd2) begin
                ph_q <= '0;
                if (ch_q == ch_idx_t'(NCH - 1)) begin
                    fin_q <= 1'b1;
                end else begin
                    ch_q <= ch_q + 1'b1;
                end
            end else begin
                ph_q <= ph_q + 1'b1;
            end
        end else if (fin_q) begin
            // extra cycle before the result is offered
            fin_q   <= 1'b0;
            valid_q <= 1'b1;
        end else if (valid_q && i_ready) begin
            valid_q <= 1'b0;
            busy_q  <= 1'b0;
            last_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            win_q <= i_win.win;
        end
        if (running) begin
            case (ph_q)
                2'd0:    wgt_q <= i_weights;
                2'd1:    sum_q <= sum_d;
                default: res_q[ch_q] <= res_val;
            endcase
        end
    end

    assign o_result = res_q;
    assign o_valid  = valid_q;
    assign o_last   = last_q;

endmodule

// ==== hw/coef_regs.sv ====
// coefficients come already in the working format; write only between images, bad taps are dropped
`timescale 1ns/1ps
`include "conv_defs.svh"

module coef_regs import conv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  coef_wr_t i_coef_wr,
    input  ch_idx_t  i_ch,
    output window_t  o_weights,
    output pixel_t   o_bias
);

    localparam int K2  = `CONV_K * `CONV_K;
    localparam int NCH = `CONV_OUT_CH;

    // per-channel weight window, same layout as the pixel window
    window_t wgt_q  [NCH];
    pixel_t  bias_q [NCH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int ch = 0; ch < NCH; ch++) begin
                wgt_q[ch]  <= '0;
                bias_q[ch] <= '0;
            end
        end else if (i_coef_wr.en) begin
            // one entry per strobe, tap K*K is the bias
            if (i_coef_wr.tap == K2) begin
                bias_q[i_coef_wr.ch] <= i_coef_wr.value;
            end else if (i_coef_wr.tap < K2) begin
                wgt_q[i_coef_wr.ch][i_coef_wr.tap] <= i_coef_wr.value;
            end
        end
    end

    // MAC picks its channel combinationally
    assign o_weights = wgt_q[i_ch];
    assign o_bias    = bias_q[i_ch];

endmodule

// ==== hw/conv_defs.svh ====
// build-time sizes for the engine; values must suit the types in conv_pkg and need a recompile
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// pixels per image row, also the depth of each row ram
`define CONV_IMG_WIDTH 8

// kernel side, window is CONV_K x CONV_K
// at least 2 so that one row ram exists
`define CONV_K 3

// signed width of pixels, weights and biases
`define CONV_VALUE_BITS 16

// fraction bits of the fixed-point format
// products carry twice this, the MAC shifts one set away
`define CONV_FRAC_BITS 8

// output channels computed one after another by the MAC
`define CONV_OUT_CH 2

// 1 clamps negative results to zero, 0 passes them through
`define CONV_RELU 1

`endif

// ==== hw/conv_pkg.sv ====
// types for one input channel only; sizes follow conv_defs.svh, so the package compiles after it
`include "conv_defs.svh"

package conv_pkg;

    // channel index is at least one bit wide, even for a single channel
    localparam int CH_BITS = (`CONV_OUT_CH > 1) ? $clog2(`CONV_OUT_CH) : 1;
    // tap index covers K*K weights plus the bias slot at K*K
    localparam int TAP_BITS = $clog2(`CONV_K * `CONV_K + 1);

    // one signed fixed-point value
    typedef logic signed [`CONV_VALUE_BITS-1:0] pixel_t;

    // K x K window, row-major, index r*K + c, row 0 oldest
    typedef pixel_t [`CONV_K*`CONV_K-1:0] window_t;

    // window beat between buffer and MAC
    typedef struct packed {
        window_t win;
        logic    last;
    } win_beat_t;

    typedef logic [CH_BITS-1:0] ch_idx_t;

    // one coefficient write, tap K*K selects the bias
    typedef struct packed {
        logic                en;
        ch_idx_t             ch;
        logic [TAP_BITS-1:0] tap;
        pixel_t              value;
    } coef_wr_t;

    // one result per output channel
    typedef pixel_t [`CONV_OUT_CH-1:0] out_vec_t;

endpackage

// ==== hw/conv_top.sv ====
// single input channel, row-major pixels with last on the final one; coef writes only when idle
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_top import conv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  pixel_t   i_pixel,
    input  logic     i_valid,
    input  logic     i_last,
    output logic     o_ready_in,
    input  coef_wr_t i_coef_wr,
    output out_vec_t o_result,
    output logic     o_valid,
    output logic     o_last,
    input  logic     i_ready
);

    // window stream between buffer and MAC
    win_beat_t win;
    logic      win_valid;
    logic      win_ready;
    // coefficient lookup for the channel in progress
    ch_idx_t   mac_ch;
    window_t   mac_weights;
    pixel_t    mac_bias;

    window_buffer buf_i (
        .clk         (clk),
        .reset       (reset),
        .i_pixel     (i_pixel),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .o_ready_in  (o_ready_in),
        .o_win       (win),
        .o_win_valid (win_valid),
        .i_win_ready (win_ready)
    );

    coef_regs coef_i (
        .clk       (clk),
        .reset     (reset),
        .i_coef_wr (i_coef_wr),
        .i_ch      (mac_ch),
        .o_weights (mac_weights),
        .o_bias    (mac_bias)
    );

    channel_mac mac_i (
        .clk         (clk),
        .reset       (reset),
        .i_win       (win),
        .i_win_valid (win_valid),
        .o_win_ready (win_ready),
        .o_ch        (mac_ch),
        .i_weights   (mac_weights),
        .i_bias      (mac_bias),
        .o_result    (o_result),
        .o_valid     (o_valid),
        .o_last      (o_last),
        .i_ready     (i_ready)
    );

endmodule

// ==== hw/row_ram.sv ====
// single image row; read data lags the address by one cycle, contents undefined after reset
`timescale 1ns/1ps

module row_ram #(
    parameter int DEPTH = 8,
    parameter int BITS  = 16
) (
    input  logic                     clk,
    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_waddr,
    input  logic [$clog2(DEPTH)-1:0] i_raddr,
    input  logic [BITS-1:0]          i_wdata,
    output logic [BITS-1:0]          o_rdata
);

    logic [BITS-1:0] mem [DEPTH];

    // read every cycle, old data on a same-address write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

endmodule

// ==== hw/window_buffer.sv ====
// emits unpadded windows only; input stalls whenever win_ready is low; last pixel must end a row
`timescale 1ns/1ps
`include "conv_defs.svh"

module window_buffer import conv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  pixel_t    i_pixel,
    input  logic      i_valid,
    input  logic      i_last,
    output logic      o_ready_in,
    output win_beat_t o_win,
    output logic      o_win_valid,
    input  logic      i_win_ready
);

    localparam int W    = `CONV_IMG_WIDTH;
    localparam int K    = `CONV_K;
    localparam int NRAM = K - 1;
    localparam int AW   = $clog2(W);
    localparam int RW   = (NRAM > 1) ? $clog2(NRAM) : 1;
    localparam int FW   = $clog2(K);

    // column of the next pixel and the row ram it lands in
    logic [AW-1:0] col_q;
    logic [AW-1:0] col_d;
    logic [RW-1:0] wr_row_q;
    // completed rows, saturates at K-1
    logic [FW-1:0] fill_q;
    logic          filled;
    logic          row_done;
    logic          accept;
    logic          last_pending;
    logic          last_taken;
    window_t       taps_q;
    window_t       taps_d;
    logic          last_q;
    logic          win_valid_q;
    pixel_t        ram_rd [NRAM];

    assign filled       = (fill_q == FW'(NRAM));
    assign row_done     = (col_q == AW'(W - 1));
    assign last_pending = win_valid_q && last_q;
    assign last_taken   = last_pending && i_win_ready;
    // hold input while MAC is busy or the final window sits on the output
    assign o_ready_in   = i_win_ready && !last_pending;
    assign accept       = i_valid && o_ready_in;

    // next column; also the read address so ram data lines up with the next pixel
    always_comb begin
        col_d = col_q;
        if (last_taken) begin
            col_d = '0;
        end else if (accept) begin
            col_d = row_done ? '0 : col_q + 1'b1;
        end
    end

    genvar r;
    generate
        for (r = 0; r < NRAM; r++) begin : g_rows
            row_ram #(.DEPTH(W), .BITS(`CONV_VALUE_BITS)) ram_i (
                .clk     (clk),
                .i_we    (accept && (wr_row_q == RW'(r))),
                .i_waddr (col_q),
                .i_raddr (col_d),
                .i_wdata (i_pixel),
                .o_rdata (ram_rd[r])
            );
        end
    endgenerate

    // shift taps left one column, new column enters at c = K-1
    always_comb begin
        int src;
        taps_d = taps_q;
        for (int rr = 0; rr < K; rr++) begin
            for (int c = 0; c < K - 1; c++) begin
                taps_d[rr*K + c] = taps_q[rr*K + c + 1];
            end
        end
        // ram being written holds the oldest row, the next one up is younger
        for (int rr = 0; rr < NRAM; rr++) begin
            src = (int'(wr_row_q) + rr) % NRAM;
            taps_d[rr*K + K - 1] = ram_rd[src];
        end
        // live pixel is the newest row
        taps_d[K*K - 1] = i_pixel;
    end

    always_ff @(posedge clk) begin
        if (reset || last_taken) begin
            col_q       <= '0;
            wr_row_q    <= '0;
            fill_q      <= '0;
            win_valid_q <= 1'b0;
            last_q      <= 1'b0;
        end else begin
            col_q <= col_d;
            if (accept) begin
                taps_q      <= taps_d;
                last_q      <= i_last;
                // full window once K-1 rows are stored and K columns shifted in
                win_valid_q <= filled && (col_q >= AW'(K - 1));
                if (row_done) begin
                    wr_row_q <= (wr_row_q == RW'(NRAM - 1)) ? '0 : wr_row_q + 1'b1;
                    if (!filled) begin
                        fill_q <= fill_q + 1'b1;
                    end
                end
            end else if (i_win_ready) begin
                // window taken with no pixel behind it
                win_valid_q <= 1'b0;
            end
        end
    end

    assign o_win.win   = taps_q;
    assign o_win.last  = last_q;
    assign o_win_valid = win_valid_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the convolution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f conv.f --top-module conv_tb --Mdir obj_dir -o conv_sim

./obj_dir/conv_sim 2>&1 | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
